// File: hw/vecslice_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes of the vector slice: register count, register bytes and
// command queue depth, plus the 3-bit vector operation codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef VECSLICE_PARAMS_SVH
`define VECSLICE_PARAMS_SVH

// register file geometry
`define NUM_VREGS  32
`define VREG_BYTES 16

// queue slots, also the host's starting credits
`define CMD_DEPTH  4

// operation codes
`define OP_VADD    3'd0
`define OP_VSUB    3'd1
`define OP_VAND    3'd2
`define OP_VMV     3'd3
`define OP_VMSEQ   3'd4

`endif

// File: hw/vecslice_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the vector slice: register, element, offset,
// index, length and opcode widths, SEW and sequencer state enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vecslice_params.svh"

package vecslice_pkg;

  // one vector register, byte addressable
  typedef logic [`VREG_BYTES-1:0][7:0] vreg_t;

  // lane value, narrow elements zero-extended
  typedef logic [31:0] elem_t;

  // element offset inside a register group
  typedef logic [6:0] offset_t;
  typedef logic [4:0] vreg_idx_t;

  // vector length, 0 to 128
  typedef logic [7:0] vl_t;
  typedef logic [2:0] vop_t;

  typedef enum logic [1:0] {SEW8, SEW16, SEW32} sew_t;

  typedef enum logic {SEQ_IDLE, SEQ_RUN} seq_state_t;

endpackage

// File: hw/vrf_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-cycle element access between the sequencer, the vector
// register file and the two-lane ALU, with one modport each
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface vrf_if
  import vecslice_pkg::*;
();

  // register selects and lane-0 offsets, from the sequencer
  vreg_idx_t   vd;
  vreg_idx_t   vs1;
  vreg_idx_t   vs2;
  offset_t     vd_offset;
  offset_t     vs1_offset;
  offset_t     vs2_offset;
  sew_t        sew;
  vl_t         vl;
  logic [1:0]  wen;
  logic        single_bit_write;
  vop_t        op;
  elem_t       scalar;

  // read lanes and v0 bits, from the register file
  elem_t [1:0] vs1_data;
  elem_t [1:0] vs2_data;
  logic [1:0]  v0_mask;

  // write lanes, from the ALU
  elem_t [1:0] w_data;

  modport seq (
    output vd, vs1, vs2, vd_offset, vs1_offset, vs2_offset,
    output sew, vl, wen, single_bit_write, op, scalar,
    input  v0_mask
  );

  modport rf (
    input  vd, vs1, vs2, vd_offset, vs1_offset, vs2_offset,
    input  sew, vl, wen, single_bit_write, w_data,
    output vs1_data, vs2_data, v0_mask
  );

  modport alu (
    input  op, scalar, sew, vs1_data, vs2_data,
    output w_data
  );

endinterface

// File: hw/vreg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector register file of 32 x 128 bits with SEW-aware two-lane read
// and write, single mask-bit writes, v0 mask reads and a host read path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vecslice_params.svh"

module vreg_file
  import vecslice_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  vrf_if.rf         rf,
  input  vreg_idx_t rd_vreg,
  input  offset_t   rd_offset,
  input  sew_t      rd_sew,
  output elem_t     rd_data,
  output logic      rd_mask
);

  vreg_t regs [`NUM_VREGS];

  // per-lane element offsets
  offset_t [1:0]    vd_off;
  offset_t [1:0]    vs1_off;
  offset_t [1:0]    vs2_off;

  // register index within the group with one spare bit for overflow
  logic [1:0][5:0]  vd_reg;
  logic [1:0][5:0]  vs1_reg;
  logic [1:0][5:0]  vs2_reg;
  logic [1:0][3:0]  vd_byte;
  logic [1:0][3:0]  vs1_byte;
  logic [1:0][3:0]  vs2_byte;
  logic [5:0]       rd_reg;
  logic [3:0]       rd_byte;

  // base register plus the group step taken by this offset
  function automatic logic [5:0] elem_reg(vreg_idx_t base, offset_t off, sew_t sew);
    logic [4:0] grp;
    case (sew)
      SEW8:    grp = {2'b00, off[6:4]};
      SEW16:   grp = {1'b0, off[6:3]};
      default: grp = off[6:2];
    endcase
    return {1'b0, base} + {1'b0, grp};
  endfunction

  // first byte of the element inside its register
  function automatic logic [3:0] elem_byte(offset_t off, sew_t sew);
    case (sew)
      SEW8:    return off[3:0];
      SEW16:   return {off[2:0], 1'b0};
      default: return {off[1:0], 2'b00};
    endcase
  endfunction

  function automatic elem_t read_elem(vreg_t r, logic [3:0] b, sew_t sew);
    case (sew)
      SEW8:    return {24'h0, r[b]};
      SEW16:   return {16'h0, r[b +: 2]};
      default: return r[b +: 4];
    endcase
  endfunction

  always_comb begin
    for (int j = 0; j < 2; j++) begin
      vd_off[j]   = rf.vd_offset + offset_t'(j);
      vs1_off[j]  = rf.vs1_offset + offset_t'(j);
      vs2_off[j]  = rf.vs2_offset + offset_t'(j);
      vd_reg[j]   = elem_reg(rf.vd, vd_off[j], rf.sew);
      vs1_reg[j]  = elem_reg(rf.vs1, vs1_off[j], rf.sew);
      vs2_reg[j]  = elem_reg(rf.vs2, vs2_off[j], rf.sew);
      vd_byte[j]  = elem_byte(vd_off[j], rf.sew);
      vs1_byte[j] = elem_byte(vs1_off[j], rf.sew);
      vs2_byte[j] = elem_byte(vs2_off[j], rf.sew);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `NUM_VREGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int j = 0; j < 2; j++) begin
        if (rf.wen[j] && rf.single_bit_write) begin
          // element i of a mask is bit i of vd without grouping
          regs[rf.vd][vd_off[j][6:3]][vd_off[j][2:0]] <= rf.w_data[j][0];
        end else if (rf.wen[j]) begin
          case (rf.sew)
            SEW8:    regs[vd_reg[j][4:0]][vd_byte[j]] <= rf.w_data[j][7:0];
            SEW16:   regs[vd_reg[j][4:0]][vd_byte[j] +: 2] <= rf.w_data[j][15:0];
            default: regs[vd_reg[j][4:0]][vd_byte[j] +: 4] <= rf.w_data[j];
          endcase
        end
      end
    end
  end

  // operand lanes and v0 bits at the destination element index
  always_comb begin
    for (int j = 0; j < 2; j++) begin
      rf.vs1_data[j] = read_elem(regs[vs1_reg[j][4:0]], vs1_byte[j], rf.sew);
      rf.vs2_data[j] = read_elem(regs[vs2_reg[j][4:0]], vs2_byte[j], rf.sew);
      rf.v0_mask[j]  = regs[0][vd_off[j][6:3]][vd_off[j][2:0]];
    end
  end

  // host read through the vs3 path
  assign rd_reg  = elem_reg(rd_vreg, rd_offset, rd_sew);
  assign rd_byte = elem_byte(rd_offset, rd_sew);
  assign rd_data = read_elem(regs[rd_reg[4:0]], rd_byte, rd_sew);
  assign rd_mask = regs[0][rd_offset[6:3]][rd_offset[2:0]];

  // a group must not run off the end of the register file
  a_group_in_range: assert property (@(posedge CLK) disable iff (!nRST)
    !rf.single_bit_write |-> !(rf.wen[0] && vd_reg[0][5]) && !(rf.wen[1] && vd_reg[1][5]));

endmodule

// File: hw/vec_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector sequencer with in-order command queue, element walk two lanes
// per cycle, masked write enables and credit return on retire
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vecslice_params.svh"

module vec_sequencer
  import vecslice_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      cmd_valid,
  input  vop_t      cmd_op,
  input  vreg_idx_t cmd_vd,
  input  vreg_idx_t cmd_vs1,
  input  vreg_idx_t cmd_vs2,
  input  sew_t      cmd_sew,
  input  vl_t       cmd_vl,
  input  logic      cmd_masked,
  input  elem_t     cmd_scalar,
  output logic      cmd_credit,
  vrf_if.seq        seq
);

  localparam int PTR_W = $clog2(`CMD_DEPTH);

  // queue slots with one array per field
  vop_t       q_op     [`CMD_DEPTH];
  vreg_idx_t  q_vd     [`CMD_DEPTH];
  vreg_idx_t  q_vs1    [`CMD_DEPTH];
  vreg_idx_t  q_vs2    [`CMD_DEPTH];
  sew_t       q_sew    [`CMD_DEPTH];
  vl_t        q_vl     [`CMD_DEPTH];
  logic       q_masked [`CMD_DEPTH];
  elem_t      q_scalar [`CMD_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             pop;
  logic             last_step;

  seq_state_t state;
  offset_t    offset;

  // command in flight
  vop_t       cur_op;
  vreg_idx_t  cur_vd;
  vreg_idx_t  cur_vs1;
  vreg_idx_t  cur_vs2;
  sew_t       cur_sew;
  vl_t        cur_vl;
  logic       cur_masked;
  elem_t      cur_scalar;

  assign pop        = (state == SEQ_IDLE) && (count != '0);
  assign last_step  = ({1'b0, offset} + 8'd2) >= cur_vl;
  assign cmd_credit = (state == SEQ_RUN) && last_step;

  always_ff @(posedge CLK) begin
    if (cmd_valid) begin
      q_op[wr_ptr]     <= cmd_op;
      q_vd[wr_ptr]     <= cmd_vd;
      q_vs1[wr_ptr]    <= cmd_vs1;
      q_vs2[wr_ptr]    <= cmd_vs2;
      q_sew[wr_ptr]    <= cmd_sew;
      q_vl[wr_ptr]     <= cmd_vl;
      q_masked[wr_ptr] <= cmd_masked;
      q_scalar[wr_ptr] <= cmd_scalar;
    end
    if (pop) begin
      cur_op     <= q_op[rd_ptr];
      cur_vd     <= q_vd[rd_ptr];
      cur_vs1    <= q_vs1[rd_ptr];
      cur_vs2    <= q_vs2[rd_ptr];
      cur_sew    <= q_sew[rd_ptr];
      cur_vl     <= q_vl[rd_ptr];
      cur_masked <= q_masked[rd_ptr];
      cur_scalar <= q_scalar[rd_ptr];
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      state  <= SEQ_IDLE;
      offset <= '0;
    end else begin
      if (cmd_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(cmd_valid) - (PTR_W+1)'(pop);
      case (state)
        SEQ_IDLE: begin
          if (pop) begin
            state  <= SEQ_RUN;
            offset <= '0;
          end
        end
        SEQ_RUN: begin
          // vl of 0 still spends one step, with no lanes enabled
          if (last_step) begin
            state <= SEQ_IDLE;
          end else begin
            offset <= offset + 7'd2;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // lanes enabled inside vl and where v0 is set when masked
  always_comb begin
    for (int j = 0; j < 2; j++) begin
      seq.wen[j] = (state == SEQ_RUN) && (({1'b0, offset} + 8'(j)) < cur_vl) &&
                   (!cur_masked || seq.v0_mask[j]);
    end
  end

  assign seq.vd               = cur_vd;
  assign seq.vs1              = cur_vs1;
  assign seq.vs2              = cur_vs2;
  assign seq.vd_offset        = offset;
  assign seq.vs1_offset       = offset;
  assign seq.vs2_offset       = offset;
  assign seq.sew              = cur_sew;
  assign seq.vl               = cur_vl;
  assign seq.single_bit_write = (cur_op == `OP_VMSEQ);
  assign seq.op               = cur_op;
  assign seq.scalar           = cur_scalar;

  a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
    cmd_valid |-> count != (PTR_W+1)'(`CMD_DEPTH));

endmodule

// File: hw/vec_lane_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-lane element ALU: add, subtract, AND, scalar splat and
// equality compare, results truncated to SEW
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vecslice_params.svh"

module vec_lane_alu
  import vecslice_pkg::*;
(
  vrf_if.alu alu
);

  elem_t       sew_mask;
  elem_t [1:0] raw;

  always_comb begin
    case (alu.sew)
      SEW8:    sew_mask = 32'h0000_00ff;
      SEW16:   sew_mask = 32'h0000_ffff;
      default: sew_mask = 32'hffff_ffff;
    endcase
  end

  // operand order follows vd = vs2 op vs1
  always_comb begin
    for (int j = 0; j < 2; j++) begin
      case (alu.op)
        `OP_VADD:  raw[j] = alu.vs2_data[j] + alu.vs1_data[j];
        `OP_VSUB:  raw[j] = alu.vs2_data[j] - alu.vs1_data[j];
        `OP_VAND:  raw[j] = alu.vs2_data[j] & alu.vs1_data[j];
        `OP_VMV:   raw[j] = alu.scalar;
        // compare gives one mask bit in lane bit 0
        `OP_VMSEQ: raw[j] = elem_t'(alu.vs2_data[j] == alu.vs1_data[j]);
        default:   raw[j] = '0;
      endcase
      alu.w_data[j] = raw[j] & sew_mask;
    end
  end

endmodule

// File: hw/vecslice_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vector slice top: command and host read ports wired to the
// sequencer, register file and lane ALU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module vecslice_top
  import vecslice_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      cmd_valid,
  input  vop_t      cmd_op,
  input  vreg_idx_t cmd_vd,
  input  vreg_idx_t cmd_vs1,
  input  vreg_idx_t cmd_vs2,
  input  sew_t      cmd_sew,
  input  vl_t       cmd_vl,
  input  logic      cmd_masked,
  input  elem_t     cmd_scalar,
  output logic      cmd_credit,
  input  vreg_idx_t rd_vreg,
  input  offset_t   rd_offset,
  input  sew_t      rd_sew,
  output elem_t     rd_data,
  output logic      rd_mask
);

  vrf_if i_vrf_if ();

  vec_sequencer i_vec_sequencer (
    .CLK        (CLK),
    .nRST       (nRST),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_vd     (cmd_vd),
    .cmd_vs1    (cmd_vs1),
    .cmd_vs2    (cmd_vs2),
    .cmd_sew    (cmd_sew),
    .cmd_vl     (cmd_vl),
    .cmd_masked (cmd_masked),
    .cmd_scalar (cmd_scalar),
    .cmd_credit (cmd_credit),
    .seq        (i_vrf_if.seq)
  );

  // host reads use the vs3 path directly
  vreg_file i_vreg_file (
    .CLK       (CLK),
    .nRST      (nRST),
    .rf        (i_vrf_if.rf),
    .rd_vreg   (rd_vreg),
    .rd_offset (rd_offset),
    .rd_sew    (rd_sew),
    .rd_data   (rd_data),
    .rd_mask   (rd_mask)
  );

  vec_lane_alu i_vec_lane_alu (
    .alu (i_vrf_if.alu)
  );

endmodule

// File: tests/vecslice_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the vector slice with clock, reset, xorshift stimulus,
// byte-level register file model, readback checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "vecslice_params.svh"

module vecslice_tb
  import vecslice_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct {
    int          op, vd, vs1, vs2, sew, vl;
    bit          masked;
    logic [31:0] scalar;
  } cmd_rec_t;

  logic CLK, nRST, cmd_valid, cmd_masked, cmd_credit, rd_mask;
  vop_t cmd_op;
  vreg_idx_t cmd_vd, cmd_vs1, cmd_vs2, rd_vreg;
  sew_t cmd_sew, rd_sew;
  vl_t cmd_vl;
  elem_t cmd_scalar, rd_data;
  offset_t rd_offset;

  logic [7:0]  model [32][16];
  cmd_rec_t    pending [$];
  logic [31:0] rng = 32'h5f43;
  int errors = 0;
  int issued = 0;
  int pulses = 0;
  int credits = `CMD_DEPTH;
  int cycles = 0;

  vecslice_top i_vecslice_top (
    .CLK(CLK), .nRST(nRST), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_vd(cmd_vd),
    .cmd_vs1(cmd_vs1), .cmd_vs2(cmd_vs2), .cmd_sew(cmd_sew), .cmd_vl(cmd_vl),
    .cmd_masked(cmd_masked), .cmd_scalar(cmd_scalar), .cmd_credit(cmd_credit),
    .rd_vreg(rd_vreg), .rd_offset(rd_offset), .rd_sew(rd_sew), .rd_data(rd_data),
    .rd_mask(rd_mask)
  );

  initial begin
    CLK = 0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // element off of the group at base with 16 >> sew elements per register
  function automatic logic [31:0] model_elem(int base, int off, int sew);
    int epr, eb, r, b;
    logic [31:0] v;
    epr = 16 >> sew;
    eb = 1 << sew;
    r = base + off / epr;
    b = (off % epr) * eb;
    v = '0;
    for (int k = 0; k < eb; k++) begin
      v[8*k +: 8] = model[r][b+k];
    end
    return v;
  endfunction

  function automatic void model_store(int base, int off, int sew, logic [31:0] v);
    int epr, eb;
    epr = 16 >> sew;
    eb = 1 << sew;
    for (int k = 0; k < eb; k++) begin
      model[base + off / epr][(off % epr) * eb + k] = v[8*k +: 8];
    end
  endfunction

  // both lanes of a step read before either lane writes
  function automatic void apply_cmd(cmd_rec_t c);
    int steps, idx;
    logic [31:0] a, b, msk;
    logic [31:0] res [2];
    bit en [2];
    msk = (c.sew == 0) ? 32'hff : (c.sew == 1) ? 32'hffff : 32'hffff_ffff;
    steps = (c.vl == 0) ? 1 : (c.vl + 1) / 2;
    for (int s = 0; s < steps; s++) begin
      for (int j = 0; j < 2; j++) begin
        idx = 2 * s + j;
        en[j] = (idx < c.vl) && (!c.masked || model[0][idx/8][idx%8]);
        a = model_elem(c.vs1, idx, c.sew);
        b = model_elem(c.vs2, idx, c.sew);
        case (c.op)
          `OP_VADD: res[j] = (b + a) & msk;
          `OP_VSUB: res[j] = (b - a) & msk;
          `OP_VAND: res[j] = b & a;
          `OP_VMV:  res[j] = c.scalar & msk;
          default:  res[j] = {31'h0, a == b};
        endcase
      end
      for (int j = 0; j < 2; j++) begin
        idx = 2 * s + j;
        if (en[j] && c.op == `OP_VMSEQ) begin
          model[c.vd][idx/8][idx%8] = res[j][0];
        end else if (en[j]) begin
          model_store(c.vd, idx, c.sew, res[j]);
        end
      end
    end
  endfunction

  // credit return updates the model in retire order
  always @(negedge CLK) begin
    if (nRST && cmd_credit) begin
      pulses++;
      credits++;
      assert (credits <= `CMD_DEPTH) else begin
        errors++;
        $display("credit count rose above the queue depth");
      end
      assert (pending.size() > 0) else begin
        errors++;
        $display("cmd_credit pulsed with no command outstanding");
      end
      if (pending.size() > 0) begin
        apply_cmd(pending.pop_front());
      end
    end
  end

  // valid stays high so the next call can follow back to back
  task automatic issue(int op, int vd, int vs1, int vs2, int sew, int vl, bit masked,
                       logic [31:0] scalar);
    cmd_rec_t c;
    c = '{op, vd, vs1, vs2, sew, vl, masked, scalar};
    @(negedge CLK);
    while (credits == 0) begin
      cmd_valid = 0;
      @(negedge CLK);
    end
    cmd_valid = 1;
    cmd_op = vop_t'(op);
    cmd_vd = vreg_idx_t'(vd);
    cmd_vs1 = vreg_idx_t'(vs1);
    cmd_vs2 = vreg_idx_t'(vs2);
    cmd_sew = sew_t'(sew);
    cmd_vl = vl_t'(vl);
    cmd_masked = masked;
    cmd_scalar = scalar;
    credits--;
    issued++;
    pending.push_back(c);
  endtask

  task automatic drain();
    @(negedge CLK);
    cmd_valid = 0;
    while (credits != `CMD_DEPTH) begin
      @(negedge CLK);
    end
  endtask

  // bases 1..16 keep every group of up to 32 elements inside the file
  task automatic random_cmd(bit masked);
    int op, sew, vl;
    op = next_rand() % 5;
    sew = next_rand() % 3;
    vl = next_rand() % 33;
    issue(op, 1 + next_rand() % 16, next_rand() % 17, next_rand() % 17, sew, vl, masked,
          next_rand());
  endtask

  task automatic compare_val(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s expected %h actual %h at vreg %0d offset %0d sew %0d", name,
               expected, actual, rd_vreg, rd_offset, rd_sew);
    end
  endtask

  task automatic read_at(int r, int o, int sew);
    @(negedge CLK);
    rd_vreg = vreg_idx_t'(r);
    rd_offset = offset_t'(o);
    rd_sew = sew_t'(sew);
    #1;
  endtask

  // every byte, every v0 bit, and the wider read widths from v0 up
  task automatic check_all();
    for (int r = 0; r < 32; r++) begin
      for (int b = 0; b < 16; b++) begin
        read_at(r, b, 0);
        compare_val("rd_data", model_elem(r, b, 0), rd_data);
      end
    end
    for (int o = 0; o < 128; o++) begin
      read_at(0, o, 2);
      compare_val("rd_data", model_elem(0, o, 2), rd_data);
      compare_val("rd_mask", {31'h0, model[0][o/8][o%8]}, {31'h0, rd_mask});
    end
    for (int o = 0; o < 128; o++) begin
      read_at(0, o, 1);
      compare_val("rd_data", model_elem(0, o, 1), rd_data);
    end
  endtask

  initial begin
    int epr, p0;
    nRST = 0;
    cmd_valid = 0;
    cmd_op = '0;
    cmd_vd = '0;
    cmd_vs1 = '0;
    cmd_vs2 = '0;
    cmd_sew = SEW8;
    cmd_vl = '0;
    cmd_masked = 0;
    cmd_scalar = '0;
    rd_vreg = '0;
    rd_offset = '0;
    rd_sew = SEW8;
    for (int r = 0; r < 32; r++) begin
      for (int b = 0; b < 16; b++) begin
        model[r][b] = 8'h00;
      end
    end
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    nRST = 1;
    // idle cycles where any stray credit trips the monitor
    repeat (20) @(negedge CLK);
    check_all();

    // splats crossing into the second register of a group, and vl of 0
    for (int s = 0; s < 3; s++) begin
      epr = 16 >> s;
      issue(`OP_VMV, 2 + 4 * s, 0, 0, s, 2 * epr, 0, next_rand());
      issue(`OP_VMV, 2 + 4 * s, 0, 0, s, epr + 1 + next_rand() % (epr - 1), 0, next_rand());
      issue(`OP_VMV, 2 + 4 * s, 0, 0, s, 0, 0, next_rand());
    end
    drain();
    check_all();

    // staircase contents, then each arithmetic op at each SEW and random commands
    for (int r = 1; r <= 24; r++) begin
      issue(`OP_VMV, r, 0, 0, 0, 16, 0, next_rand());
      issue(`OP_VMV, r, 0, 0, 1, 1 + next_rand() % 7, 0, next_rand());
    end
    for (int op = `OP_VADD; op <= `OP_VAND; op++) begin
      for (int s = 0; s < 3; s++) begin
        issue(op, 1 + next_rand() % 16, next_rand() % 17, next_rand() % 17, s,
              8 + next_rand() % 25, 0, 0);
      end
    end
    repeat (16) random_cmd(0);
    drain();
    check_all();

    // v0 from compares, then masked commands
    issue(`OP_VMSEQ, 0, 5, 5, 0, 24, 0, 0);
    issue(`OP_VMSEQ, 0, 7, 9, 1, 10, 0, 0);
    issue(`OP_VMSEQ, 0, 11, 11, 2, 3, 0, 0);
    issue(`OP_VMV, 12, 0, 0, 2, 28, 1, next_rand());
    repeat (10) random_cmd(1);
    drain();
    check_all();

    // full queue back to back with each command reading the previous result
    p0 = pulses;
    issue(`OP_VMV, 3, 0, 0, 1, 16, 0, next_rand());
    issue(`OP_VADD, 4, 3, 3, 1, 16, 0, 0);
    issue(`OP_VSUB, 5, 1, 4, 1, 13, 0, 0);
    issue(`OP_VAND, 3, 5, 4, 2, 7, 0, 0);
    drain();
    check_all();
    compare_val("cmd_credit pulses", `CMD_DEPTH, pulses - p0);

    repeat (10) @(negedge CLK);
    compare_val("cmd_credit pulses", issued, pulses);
    $display("errors %0d, commands %0d, credit pulses %0d", errors, issued, pulses);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // limit grows with the commands issued so far
  initial begin
    while (cycles < 200 * issued + 1000) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout: simulation ran %0d cycles without finishing", cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: vecslice.f
+incdir+hw
hw/vecslice_pkg.sv
hw/vrf_if.sv
hw/vreg_file.sv
hw/vec_sequencer.sv
hw/vec_lane_alu.sv
hw/vecslice_top.sv
tests/vecslice_tb.sv
